// ==== mmu_defs.svh ====
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// widths
`define MMU_VADDR_W     32
`define MMU_VPPN_W      19
`define MMU_PPN_W       20
`define MMU_ASID_W      10
`define MMU_TLB_NUM     16
`define MMU_TLB_IDX_W   4
`define MMU_CSR_NUM_W   9

// crmd fields
`define MMU_CRMD_PLV    1:0
`define MMU_CRMD_DA     3
`define MMU_CRMD_PG     4

// tlbidx / tlbehi fields
`define MMU_TLBIDX_IDX  3:0
`define MMU_TLBIDX_NE   31
`define MMU_TLBEHI_VPPN 31:13

// tlbelo0 and tlbelo1 share one layout
`define MMU_TLBELO_V    0
`define MMU_TLBELO_D    1
`define MMU_TLBELO_PLV  3:2
`define MMU_TLBELO_G    6
`define MMU_TLBELO_PPN  27:8

// direct-mapped windows
`define MMU_DMW_PLV0    0
`define MMU_DMW_PLV3    3
`define MMU_DMW_PSEG    27:25
`define MMU_DMW_VSEG    31:29

`endif

// ==== mmu_pkg.sv ====
`include "mmu_defs.svh"

package mmu_pkg;

    // translation register numbers
    typedef enum logic [`MMU_CSR_NUM_W-1:0] {
        CSR_CRMD    = 9'h000,
        CSR_TLBIDX  = 9'h010,
        CSR_TLBEHI  = 9'h011,
        CSR_TLBELO0 = 9'h012,
        CSR_TLBELO1 = 9'h013,
        CSR_ASID    = 9'h018,
        CSR_DMW0    = 9'h180,
        CSR_DMW1    = 9'h181
    } csr_num_t;

    typedef enum logic [1:0] {
        TLB_OP_WRITE    = 2'd0,
        TLB_OP_INV_ALL  = 2'd1,
        TLB_OP_INV_ASID = 2'd2
    } tlb_op_t;

    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        // refill
        EXC_TLBR = 3'd1,
        // load or store on invalid page
        EXC_PIL  = 3'd2,
        EXC_PIS  = 3'd3,
        // privilege
        EXC_PPI  = 3'd4,
        // store to clean page
        EXC_PME  = 3'd5
    } xlate_exc_t;

    // one half of an even/odd page pair, 4 KiB
    typedef struct packed {
        logic [`MMU_PPN_W-1:0] ppn;
        logic [1:0]            plv;
        logic                  d;
        logic                  v;
    } tlb_page_t;

    typedef struct packed {
        logic                   e;
        logic [`MMU_VPPN_W-1:0] vppn;
        logic [`MMU_ASID_W-1:0] asid;
        logic                   g;
        tlb_page_t              page0;
        tlb_page_t              page1;
    } tlb_entry_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

endpackage

// ==== mmu_if.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

// tlb write and invalidate, one-cycle strobe
interface tlb_write_if;
    import mmu_pkg::*;

    logic                      we;
    tlb_op_t                   op;
    logic [`MMU_TLB_IDX_W-1:0] index;
    tlb_entry_t                entry;
    logic [`MMU_ASID_W-1:0]    asid;

    modport master (output we, op, index, entry, asid);
    modport slave  (input  we, op, index, entry, asid);
endinterface

// single lookup port, answered in the same cycle
interface tlb_search_if;
    import mmu_pkg::*;

    logic [`MMU_VPPN_W-1:0]    vppn;
    logic [`MMU_ASID_W-1:0]    asid;
    logic                      odd;
    logic                      found;
    logic [`MMU_TLB_IDX_W-1:0] index;
    tlb_page_t                 page;

    modport requester (output vppn, asid, odd, input  found, index, page);
    modport responder (input  vppn, asid, odd, output found, index, page);
endinterface

// mode and window state seen by the translation pipeline
interface xlate_cfg_if;
    import mmu_pkg::*;

    logic                   da;
    logic                   pg;
    logic [1:0]             plv;
    logic [`MMU_ASID_W-1:0] asid;
    dmw_t                   dmw0;
    dmw_t                   dmw1;

    modport source (output da, pg, plv, asid, dmw0, dmw1);
    modport sink   (input  da, pg, plv, asid, dmw0, dmw1);
endinterface

// ==== mmu_csr.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_csr (
    input  logic              clk,
    input  logic              reset,
    input  logic              cfg_we,
    input  mmu_pkg::csr_num_t cfg_num,
    input  logic [31:0]       cfg_wdata,
    input  logic              cmd_valid,
    input  mmu_pkg::tlb_op_t  cmd_op,
    tlb_write_if.master       tlb_wr,
    xlate_cfg_if.source       cfg
);
    import mmu_pkg::*;

    logic [1:0]                crmd_plv;
    logic                      crmd_da;
    logic                      crmd_pg;
    logic [`MMU_ASID_W-1:0]    cur_asid;
    logic [`MMU_TLB_IDX_W-1:0] tlbidx_index;
    logic                      tlbidx_ne;
    logic [`MMU_VPPN_W-1:0]    tlbehi_vppn;
    tlb_page_t                 elo0;
    tlb_page_t                 elo1;
    logic                      elo0_g;
    logic                      elo1_g;
    dmw_t                      dmw0;
    dmw_t                      dmw1;

    function automatic tlb_page_t elo_page(logic [31:0] w);
        tlb_page_t p;
        p.ppn = w[`MMU_TLBELO_PPN];
        p.plv = w[`MMU_TLBELO_PLV];
        p.d   = w[`MMU_TLBELO_D];
        p.v   = w[`MMU_TLBELO_V];
        return p;
    endfunction

    function automatic dmw_t dmw_word(logic [31:0] w);
        dmw_t d;
        d.plv0 = w[`MMU_DMW_PLV0];
        d.plv3 = w[`MMU_DMW_PLV3];
        d.pseg = w[`MMU_DMW_PSEG];
        d.vseg = w[`MMU_DMW_VSEG];
        return d;
    endfunction

    // only the defined fields are kept, the rest of the word is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv     <= 2'd0;
            crmd_da      <= 1'b1;
            crmd_pg      <= 1'b0;
            cur_asid     <= '0;
            tlbidx_index <= '0;
            tlbidx_ne    <= 1'b0;
            tlbehi_vppn  <= '0;
            elo0         <= '0;
            elo1         <= '0;
            elo0_g       <= 1'b0;
            elo1_g       <= 1'b0;
            dmw0         <= '0;
            dmw1         <= '0;
        end else if (cfg_we) begin
            case (cfg_num)
                CSR_CRMD: begin
                    crmd_plv <= cfg_wdata[`MMU_CRMD_PLV];
                    crmd_da  <= cfg_wdata[`MMU_CRMD_DA];
                    crmd_pg  <= cfg_wdata[`MMU_CRMD_PG];
                end
                CSR_ASID: cur_asid <= cfg_wdata[`MMU_ASID_W-1:0];
                CSR_TLBIDX: begin
                    tlbidx_index <= cfg_wdata[`MMU_TLBIDX_IDX];
                    tlbidx_ne    <= cfg_wdata[`MMU_TLBIDX_NE];
                end
                CSR_TLBEHI: tlbehi_vppn <= cfg_wdata[`MMU_TLBEHI_VPPN];
                CSR_TLBELO0: begin
                    elo0   <= elo_page(cfg_wdata);
                    elo0_g <= cfg_wdata[`MMU_TLBELO_G];
                end
                CSR_TLBELO1: begin
                    elo1   <= elo_page(cfg_wdata);
                    elo1_g <= cfg_wdata[`MMU_TLBELO_G];
                end
                CSR_DMW0: dmw0 <= dmw_word(cfg_wdata);
                CSR_DMW1: dmw1 <= dmw_word(cfg_wdata);
                default: ;
            endcase
        end
    end

    // tlb command built from the registers as they stand now
    assign tlb_wr.we    = cmd_valid;
    assign tlb_wr.op    = cmd_op;
    assign tlb_wr.index = tlbidx_index;
    assign tlb_wr.asid  = cur_asid;
    assign tlb_wr.entry = '{
        e:     ~tlbidx_ne,
        vppn:  tlbehi_vppn,
        asid:  cur_asid,
        // entry is global only if both halves say so
        g:     elo0_g & elo1_g,
        page0: elo0,
        page1: elo1
    };

    assign cfg.da   = crmd_da;
    assign cfg.pg   = crmd_pg;
    assign cfg.plv  = crmd_plv;
    assign cfg.asid = cur_asid;
    assign cfg.dmw0 = dmw0;
    assign cfg.dmw1 = dmw1;

endmodule

// ==== tlb_array.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_array (
    input  logic            clk,
    input  logic            reset,
    tlb_write_if.slave      wr,
    tlb_search_if.responder srch
);
    import mmu_pkg::*;

    localparam int IDX_W = `MMU_TLB_IDX_W;

    tlb_entry_t       ent [`MMU_TLB_NUM];
    logic [`MMU_TLB_NUM-1:0] ent_e;
    logic [IDX_W-1:0] hit_idx;
    logic             hit;

    // entry payload, e bits live in ent_e
    always_ff @(posedge clk) begin
        if (wr.we && wr.op == TLB_OP_WRITE) begin
            ent[wr.index] <= wr.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_e <= '0;
        end else if (wr.we) begin
            case (wr.op)
                TLB_OP_WRITE:   ent_e[wr.index] <= wr.entry.e;
                TLB_OP_INV_ALL: ent_e <= '0;
                TLB_OP_INV_ASID: begin
                    // global entries survive
                    for (int i = 0; i < `MMU_TLB_NUM; i++) begin
                        if (!ent[i].g && ent[i].asid == wr.asid) begin
                            ent_e[i] <= 1'b0;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // scan from the top so the lowest matching index wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = `MMU_TLB_NUM - 1; i >= 0; i--) begin
            if (ent_e[i] && ent[i].vppn == srch.vppn &&
                (ent[i].g || ent[i].asid == srch.asid)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign srch.found = hit;
    assign srch.index = hit_idx;
    assign srch.page  = srch.odd ? ent[hit_idx].page1 : ent[hit_idx].page0;

endmodule

// ==== addr_xlate.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module addr_xlate (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic [`MMU_VADDR_W-1:0] req_vaddr,
    input  logic                    req_store,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [`MMU_VADDR_W-1:0] rsp_paddr,
    output mmu_pkg::xlate_exc_t     rsp_exc,
    xlate_cfg_if.sink               cfg,
    tlb_search_if.requester         srch
);
    import mmu_pkg::*;

    logic                    s1_valid;
    logic [`MMU_VADDR_W-1:0] s1_vaddr;
    logic                    s1_store;
    logic                    s1_advance;
    logic                    s2_valid;
    logic                    s2_ready;
    logic [`MMU_VADDR_W-1:0] s2_paddr;
    xlate_exc_t              s2_exc;
    logic                    direct;
    logic                    dmw0_hit;
    logic                    dmw1_hit;
    logic [`MMU_VADDR_W-1:0] xl_paddr;
    xlate_exc_t              xl_exc;

    // window matches its segment and is open for the current plv
    function automatic logic win_hit(dmw_t w, logic [1:0] plv, logic [2:0] seg);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3);
        return plv_ok && (w.vseg == seg);
    endfunction

    // handshake between the stages
    assign s2_ready   = !s2_valid || rsp_ready;
    assign s1_advance = s1_valid && s2_ready;
    assign req_ready  = !s1_valid || s2_ready;

    assign srch.vppn = s1_vaddr[`MMU_VADDR_W-1:12+1];
    assign srch.odd  = s1_vaddr[12];
    assign srch.asid = cfg.asid;

    assign direct   = cfg.da || !cfg.pg;
    assign dmw0_hit = win_hit(cfg.dmw0, cfg.plv, s1_vaddr[31:29]);
    assign dmw1_hit = win_hit(cfg.dmw1, cfg.plv, s1_vaddr[31:29]);

    always_comb begin
        xl_paddr = '0;
        xl_exc   = EXC_NONE;
        if (direct) begin
            xl_paddr = s1_vaddr;
        end else if (dmw0_hit) begin
            xl_paddr = {cfg.dmw0.pseg, s1_vaddr[28:0]};
        end else if (dmw1_hit) begin
            xl_paddr = {cfg.dmw1.pseg, s1_vaddr[28:0]};
        end else if (!srch.found) begin
            xl_exc = EXC_TLBR;
        end else if (!srch.page.v) begin
            xl_exc = s1_store ? EXC_PIS : EXC_PIL;
        end else if (cfg.plv > srch.page.plv) begin
            xl_exc = EXC_PPI;
        end else if (s1_store && !srch.page.d) begin
            xl_exc = EXC_PME;
        end else begin
            xl_paddr = {srch.page.ppn, s1_vaddr[11:0]};
        end
    end

    // stage 1 request
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            s1_vaddr <= req_vaddr;
            s1_store <= req_store;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s2_paddr <= '0;
            s2_exc   <= EXC_NONE;
        end else begin
            if (req_ready) begin
                s1_valid <= req_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
            // stage 2 holds while the consumer stalls
            if (s1_advance) begin
                s2_paddr <= xl_paddr;
                s2_exc   <= xl_exc;
            end
        end
    end

    assign rsp_valid = s2_valid;
    assign rsp_paddr = s2_paddr;
    assign rsp_exc   = s2_exc;

endmodule

// ==== mmu_top.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_top (
    input  logic                    clk,
    input  logic                    reset,
    // translation register writes
    input  logic                    cfg_we,
    input  mmu_pkg::csr_num_t       cfg_num,
    input  logic [31:0]             cfg_wdata,
    // tlb commands
    input  logic                    cmd_valid,
    input  mmu_pkg::tlb_op_t        cmd_op,
    // translation request
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic [`MMU_VADDR_W-1:0] req_vaddr,
    input  logic                    req_store,
    // translation response
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [`MMU_VADDR_W-1:0] rsp_paddr,
    output mmu_pkg::xlate_exc_t     rsp_exc
);

    tlb_write_if  tlb_wr_bus ();
    tlb_search_if srch_bus ();
    xlate_cfg_if  cfg_bus ();

    mmu_csr csr_i (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_num   (cfg_num),
        .cfg_wdata (cfg_wdata),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .tlb_wr    (tlb_wr_bus),
        .cfg       (cfg_bus)
    );

    tlb_array tlb_i (
        .clk   (clk),
        .reset (reset),
        .wr    (tlb_wr_bus),
        .srch  (srch_bus)
    );

    addr_xlate xlate_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_vaddr (req_vaddr),
        .req_store (req_store),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_paddr (rsp_paddr),
        .rsp_exc   (rsp_exc),
        .cfg       (cfg_bus),
        .srch      (srch_bus)
    );

endmodule

// ==== mmu_assert.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_assert (
    input logic                    clk,
    input logic                    reset,
    input logic                    rsp_valid,
    input logic                    rsp_ready,
    input logic [`MMU_VADDR_W-1:0] rsp_paddr,
    input mmu_pkg::xlate_exc_t     rsp_exc
);
    import mmu_pkg::*;

    int unsigned failures = 0;

    // pipeline comes out of reset empty
    idle_after_reset: assert property (@(posedge clk) reset |=> !rsp_valid)
        else begin
            failures++;
            $error("rsp_valid high after a reset cycle");
        end

    // stalled response keeps valid and payload
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_paddr) && $stable(rsp_exc))
        else begin
            failures++;
            $error("response changed while stalled");
        end

    exc_defined: assert property (@(posedge clk) disable iff (reset)
        rsp_exc inside {EXC_NONE, EXC_TLBR, EXC_PIL, EXC_PIS, EXC_PPI, EXC_PME})
        else begin
            failures++;
            $error("rsp_exc holds an undefined code");
        end

endmodule

bind mmu_top mmu_assert assert_i (
    .clk       (clk),
    .reset     (reset),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_paddr (rsp_paddr),
    .rsp_exc   (rsp_exc)
);

// ==== tb_mmu.sv ====
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tb_mmu;
    import mmu_pkg::*;

    localparam int          CYCLES_PER_STEP = 40;
    localparam logic [31:0] SEED            = 32'h04549348;

    typedef enum int {K_REG, K_CMD, K_XLATE, K_END} step_kind_t;

    // one row of the stimulus table
    typedef struct {
        step_kind_t              kind;
        csr_num_t                num;
        logic [31:0]             data;
        tlb_op_t                 op;
        logic [`MMU_VADDR_W-1:0] vaddr;
        logic                    store;
        logic [`MMU_VADDR_W-1:0] paddr;
        xlate_exc_t              exc;
        int                      test;
    } step_t;

    logic                    clk;
    logic                    reset;
    logic                    cfg_we;
    csr_num_t                cfg_num;
    logic [31:0]             cfg_wdata;
    logic                    cmd_valid;
    tlb_op_t                 cmd_op;
    logic                    req_valid;
    logic                    req_ready;
    logic [`MMU_VADDR_W-1:0] req_vaddr;
    logic                    req_store;
    logic                    rsp_valid;
    logic                    rsp_ready;
    logic [`MMU_VADDR_W-1:0] rsp_paddr;
    xlate_exc_t              rsp_exc;

    step_t steps [$];
    step_t pending [$];
    string test_name [1:6];
    bit    table_built = 1'b0;
    int    checks = 0;
    int    errors = 0;
    int    mark_checks = 0;
    int    mark_errors = 0;
    int    tests_done = 0;

    mmu_top mmu_top_i (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_num   (cfg_num),
        .cfg_wdata (cfg_wdata),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_vaddr (req_vaddr),
        .req_store (req_store),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_paddr (rsp_paddr),
        .rsp_exc   (rsp_exc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random consumer back-pressure with about one stall in four cycles
    initial begin
        void'($urandom(SEED));
        rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            rsp_ready = ($urandom % 4) != 0;
        end
    end

    function automatic step_t idle_step(step_kind_t kind);
        step_t s;
        s.kind  = kind;
        s.num   = CSR_CRMD;
        s.data  = '0;
        s.op    = TLB_OP_WRITE;
        s.vaddr = '0;
        s.store = 1'b0;
        s.paddr = '0;
        s.exc   = EXC_NONE;
        s.test  = 0;
        return s;
    endfunction

    task automatic reg_write(csr_num_t num, logic [31:0] data);
        step_t s;
        s      = idle_step(K_REG);
        s.num  = num;
        s.data = data;
        steps.push_back(s);
    endtask

    task automatic tlb_command(tlb_op_t op);
        step_t s;
        s    = idle_step(K_CMD);
        s.op = op;
        steps.push_back(s);
    endtask

    task automatic translate(logic [31:0] vaddr, logic store, logic [31:0] paddr,
                             xlate_exc_t exc);
        step_t s;
        s       = idle_step(K_XLATE);
        s.vaddr = vaddr;
        s.store = store;
        s.paddr = paddr;
        s.exc   = exc;
        steps.push_back(s);
    endtask

    task automatic close_test(int test);
        step_t s;
        s      = idle_step(K_END);
        s.test = test;
        steps.push_back(s);
    endtask

    task automatic build_table();
        test_name[1] = "direct address mode";
        test_name[2] = "direct-mapped windows";
        test_name[3] = "tlb lookup and asid";
        test_name[4] = "page exceptions";
        test_name[5] = "tlb invalidation";
        test_name[6] = "burst with back-pressure";
        // da=1 after reset
        translate(32'h1234_5678, 1'b0, 32'h1234_5678, EXC_NONE);
        translate(32'hFFFF_F000, 1'b1, 32'hFFFF_F000, EXC_NONE);
        translate(32'h0000_0004, 1'b0, 32'h0000_0004, EXC_NONE);
        translate(32'h8000_0000, 1'b0, 32'h8000_0000, EXC_NONE);
        close_test(1);
        // both windows on vseg 4 with dmw0 open to plv0 only
        reg_write(CSR_CRMD, 32'h0000_0010);
        reg_write(CSR_DMW0, 32'h8200_0001);
        reg_write(CSR_DMW1, 32'h8400_0009);
        translate(32'h8123_4567, 1'b0, 32'h2123_4567, EXC_NONE);
        translate(32'h0000_1000, 1'b0, 32'h0000_0000, EXC_TLBR);
        reg_write(CSR_CRMD, 32'h0000_0013);
        translate(32'h8123_4567, 1'b1, 32'h4123_4567, EXC_NONE);
        reg_write(CSR_DMW1, 32'h8400_0001);
        translate(32'h8123_4567, 1'b0, 32'h0000_0000, EXC_TLBR);
        close_test(2);
        // entry 3 under asid 5 with even ppn 12345 and odd ppn 0abcd at plv 3
        reg_write(CSR_CRMD, 32'h0000_0010);
        reg_write(CSR_ASID, 32'h0000_0005);
        reg_write(CSR_TLBEHI, 32'h0040_0000);
        reg_write(CSR_TLBELO0, 32'h0123_4503);
        reg_write(CSR_TLBELO1, 32'h00AB_CD0F);
        reg_write(CSR_TLBIDX, 32'h0000_0003);
        tlb_command(TLB_OP_WRITE);
        translate(32'h0040_0123, 1'b0, 32'h1234_5123, EXC_NONE);
        translate(32'h0040_1ABC, 1'b1, 32'h0ABC_DABC, EXC_NONE);
        // entry 4 is global and tagged with asid 5 as well
        reg_write(CSR_TLBEHI, 32'h0080_0000);
        reg_write(CSR_TLBELO0, 32'h0001_1143);
        reg_write(CSR_TLBELO1, 32'h0002_2243);
        reg_write(CSR_TLBIDX, 32'h0000_0004);
        tlb_command(TLB_OP_WRITE);
        reg_write(CSR_ASID, 32'h0000_0006);
        translate(32'h0040_0123, 1'b0, 32'h0000_0000, EXC_TLBR);
        translate(32'h0080_0010, 1'b0, 32'h0011_1010, EXC_NONE);
        reg_write(CSR_ASID, 32'h0000_0007);
        translate(32'h0080_1020, 1'b1, 32'h0022_2020, EXC_NONE);
        close_test(3);
        // entry 5 under asid 7 with an invalid even page and a clean odd page at plv 0
        reg_write(CSR_TLBEHI, 32'h00C0_0000);
        reg_write(CSR_TLBELO0, 32'h0003_3300);
        reg_write(CSR_TLBELO1, 32'h0004_4401);
        reg_write(CSR_TLBIDX, 32'h0000_0005);
        tlb_command(TLB_OP_WRITE);
        translate(32'h00C0_0008, 1'b0, 32'h0000_0000, EXC_PIL);
        translate(32'h00C0_0008, 1'b1, 32'h0000_0000, EXC_PIS);
        translate(32'h00C0_1008, 1'b0, 32'h0044_4008, EXC_NONE);
        translate(32'h00C0_1008, 1'b1, 32'h0000_0000, EXC_PME);
        reg_write(CSR_CRMD, 32'h0000_0013);
        translate(32'h00C0_1008, 1'b0, 32'h0000_0000, EXC_PPI);
        translate(32'h00C0_1008, 1'b1, 32'h0000_0000, EXC_PPI);
        reg_write(CSR_CRMD, 32'h0000_0010);
        close_test(4);
        // asid 5 drops entry 3 and keeps the global entry 4
        reg_write(CSR_ASID, 32'h0000_0005);
        tlb_command(TLB_OP_INV_ASID);
        translate(32'h0040_0123, 1'b0, 32'h0000_0000, EXC_TLBR);
        translate(32'h0080_0010, 1'b0, 32'h0011_1010, EXC_NONE);
        reg_write(CSR_ASID, 32'h0000_0007);
        translate(32'h00C0_1008, 1'b0, 32'h0044_4008, EXC_NONE);
        tlb_command(TLB_OP_INV_ALL);
        translate(32'h0080_0010, 1'b0, 32'h0000_0000, EXC_TLBR);
        translate(32'h00C0_1008, 1'b0, 32'h0000_0000, EXC_TLBR);
        close_test(5);
        // entry 0 under asid 9 feeds the back-to-back requests
        reg_write(CSR_ASID, 32'h0000_0009);
        reg_write(CSR_TLBEHI, 32'h0100_0000);
        reg_write(CSR_TLBELO0, 32'h0555_5503);
        reg_write(CSR_TLBELO1, 32'h0666_6603);
        reg_write(CSR_TLBIDX, 32'h0000_0000);
        tlb_command(TLB_OP_WRITE);
        translate(32'h0100_0000, 1'b0, 32'h5555_5000, EXC_NONE);
        translate(32'h0100_1FFC, 1'b1, 32'h6666_6FFC, EXC_NONE);
        translate(32'h0100_0ABC, 1'b0, 32'h5555_5ABC, EXC_NONE);
        translate(32'h8000_0010, 1'b0, 32'h2000_0010, EXC_NONE);
        translate(32'h0200_0000, 1'b0, 32'h0000_0000, EXC_TLBR);
        translate(32'h0100_1004, 1'b0, 32'h6666_6004, EXC_NONE);
        translate(32'h9FFF_FFFC, 1'b0, 32'h3FFF_FFFC, EXC_NONE);
        translate(32'h0100_0FF0, 1'b1, 32'h5555_5FF0, EXC_NONE);
        translate(32'h0100_1000, 1'b0, 32'h6666_6000, EXC_NONE);
        translate(32'h8000_0000, 1'b1, 32'h2000_0000, EXC_NONE);
        close_test(6);
    endtask

    task automatic idle_inputs();
        cfg_we    = 1'b0;
        cmd_valid = 1'b0;
        req_valid = 1'b0;
    endtask

    // leaves the driver at a falling edge with no request in flight
    task automatic wait_empty();
        @(negedge clk);
        idle_inputs();
        while (pending.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_step(step_t s);
        if (s.kind == K_XLATE) begin
            @(negedge clk);
            idle_inputs();
        end else begin
            wait_empty();
        end
        case (s.kind)
            K_REG: begin
                cfg_we    = 1'b1;
                cfg_num   = s.num;
                cfg_wdata = s.data;
                @(posedge clk);
            end
            K_CMD: begin
                cmd_valid = 1'b1;
                cmd_op    = s.op;
                @(posedge clk);
            end
            K_XLATE: begin
                req_valid = 1'b1;
                req_vaddr = s.vaddr;
                req_store = s.store;
                @(posedge clk);
                while (!req_ready) begin
                    @(posedge clk);
                end
                pending.push_back(s);
            end
            K_END: begin
                $display("test %0d %s: %0d checks, %0d errors", s.test, test_name[s.test],
                         checks - mark_checks, errors - mark_errors);
                mark_checks = checks;
                mark_errors = errors;
                tests_done++;
            end
            default: ;
        endcase
    endtask

    // response checker pops in request order on each transfer
    always @(posedge clk) begin
        step_t exp;
        if (!reset && rsp_valid && rsp_ready) begin
            if (pending.size() == 0) begin
                $display("response at %0t arrived with no request outstanding", $time);
                errors++;
            end else begin
                exp = pending.pop_front();
                checks++;
                if (rsp_paddr !== exp.paddr || rsp_exc !== exp.exc) begin
                    $display("FAILED %0t: vaddr %h store %0d gave %h %s, expected %h %s",
                             $time, exp.vaddr, exp.store, rsp_paddr, rsp_exc.name(),
                             exp.paddr, exp.exc.name());
                    errors++;
                end
            end
        end
    end

    initial begin
        wait (table_built);
        repeat ((steps.size() + 5) * CYCLES_PER_STEP) @(posedge clk);
        $display("watchdog expired at %0t with %0d responses outstanding",
                 $time, pending.size());
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int total;
        reset     = 1'b1;
        cfg_we    = 1'b0;
        cfg_num   = CSR_CRMD;
        cfg_wdata = '0;
        cmd_valid = 1'b0;
        cmd_op    = TLB_OP_WRITE;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_store = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        wait_empty();
        total = errors + mmu_top_i.assert_i.failures;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_done, checks, errors, mmu_top_i.assert_i.failures);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
mmu_pkg.sv
mmu_if.sv
mmu_csr.sv
tlb_array.sv
addr_xlate.sv
mmu_top.sv
mmu_assert.sv
tb_mmu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
